/* list.f */
design/edge_capture_pkg.sv
design/edge_pixel_packer.sv
design/frame_buffer_ram.sv
design/edge_pixel_reader.sv
design/edge_count_stats.sv
design/edge_capture_top.sv
tb/edge_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the edge capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module edge_capture_tb -o edge_capture_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/edge_capture_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* tb/edge_capture_tb.sv */
`timescale 1ns/1ps

module edge_capture_tb import edge_capture_pkg::*; ();

    localparam int clk_period      = 20;
    localparam int random_reads    = 400;                    // Cycles per random read burst
    localparam int frame_cycles    = frame_pixels * 10 / 7;  // Stream at about 70 percent
    localparam int read_cycles     = frame_pixels + random_reads + 100;
    localparam int watchdog_cycles = 4 * frame_cycles + 3 * read_cycles + 2000;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         canny_de;
    logic                         canny_bit;
    logic                         rd_req;
    logic [pixel_index_width-1:0] rd_index;
    logic                         frame_tick;
    logic                         rd_valid;
    logic                         rd_pixel;
    logic [count_width-1:0]       edge_count;
    logic                         count_valid;

    bit model [frame_pixels];   // Edge bits of the newest frame
    int model_count;            // Ones in the newest frame
    int cycle       = 0;
    int checks      = 0;
    int errors      = 0;
    int tick_count  = 0;
    int valid_count = 0;

    // Reads in flight, oldest first
    int exp_cycle_q[$];
    int exp_index_q[$];
    bit exp_bit_q[$];

    edge_capture_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .canny_de    (canny_de),
        .canny_bit   (canny_bit),
        .rd_req      (rd_req),
        .rd_index    (rd_index),
        .frame_tick  (frame_tick),
        .rd_valid    (rd_valid),
        .rd_pixel    (rd_pixel),
        .edge_count  (edge_count),
        .count_valid (count_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check(input int actual, input int expected, input string msg);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
        end
    endtask

    // Outputs are registered, so they are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (exp_cycle_q.size() > 0 && exp_cycle_q[0] == cycle) begin
                check(int'(rd_valid), 1, "rd_valid two cycles after request");
                check(int'(rd_pixel), int'(exp_bit_q[0]),
                      $sformatf("rd_pixel at index %0d", exp_index_q[0]));
                void'(exp_cycle_q.pop_front());
                void'(exp_index_q.pop_front());
                void'(exp_bit_q.pop_front());
            end else if (rd_valid) begin
                errors++;
                $display("Error at %0t ns: rd_valid high with no read pending", $time);
            end
            if (frame_tick) tick_count++;
            if (count_valid) valid_count++;
        end
    end

    // Streams one frame, then checks the tick and the edge count
    task automatic send_frame(input int frame_no);
        int density;
        int sent;
        int last_cycle;
        int wait_cnt;
        density     = int'($urandom_range(60, 5)); // Edge density in percent
        model_count = 0;
        sent        = 0;
        last_cycle  = 0;
        while (sent < frame_pixels) begin
            @(negedge clk);
            if (($urandom % 10) < 7) begin
                canny_de    = 1'b1;
                canny_bit   = (($urandom % 100) < density);
                model[sent] = canny_bit;
                model_count = model_count + int'(canny_bit);
                sent++;
                last_cycle  = cycle; // Cycle that carries this strobe
            end else begin
                canny_de  = 1'b0;
                canny_bit = 1'($urandom); // Ignored without the strobe
            end
        end
        @(negedge clk);
        canny_de  = 1'b0;
        canny_bit = 1'b0;
        wait_cnt  = 0;
        while (!frame_tick && wait_cnt < 8) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!frame_tick) begin
            errors++;
            $display("Error at %0t ns: no frame_tick after frame %0d", $time, frame_no);
        end else begin
            check(cycle - last_cycle, 2, $sformatf("frame_tick delay, frame %0d", frame_no));
            @(negedge clk);
            check(int'(count_valid), 1, $sformatf("count_valid after frame %0d", frame_no));
            check(int'(edge_count), model_count,
                  $sformatf("edge_count of frame %0d", frame_no));
        end
    endtask

    task automatic issue_read(input int idx);
        rd_req   = 1'b1;
        rd_index = pixel_index_width'(idx);
        exp_cycle_q.push_back(cycle + 2);
        exp_index_q.push_back(idx);
        exp_bit_q.push_back(model[idx]);
    endtask

    task automatic drain_reads();
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        rd_req = 1'b0;
        while (exp_cycle_q.size() > 0 && wait_cnt < 10) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_cycle_q.size() > 0) begin
            errors++;
            $display("Error at %0t ns: %0d read responses never arrived",
                     $time, exp_cycle_q.size());
            exp_cycle_q.delete();
            exp_index_q.delete();
            exp_bit_q.delete();
        end
    endtask

    // Random indices, some requests back to back
    task automatic random_read_burst();
        for (int i = 0; i < random_reads; i++) begin
            @(negedge clk);
            if (($urandom % 3) != 0) begin
                issue_read(int'($urandom % frame_pixels));
            end else begin
                rd_req = 1'b0;
            end
        end
        drain_reads();
    endtask

    task automatic sweep_reads();
        for (int idx = 0; idx < frame_pixels; idx++) begin
            @(negedge clk);
            issue_read(idx);
        end
        drain_reads();
    endtask

    initial begin
        void'($urandom(32'h3d63));
        reset     = 1'b1;
        canny_de  = 1'b0;
        canny_bit = 1'b0;
        rd_req    = 1'b0;
        rd_index  = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check(int'(frame_tick), 0, "frame_tick after reset");
        check(int'(count_valid), 0, "count_valid after reset");
        check(int'(rd_valid), 0, "rd_valid after reset");
        check(int'(edge_count), 0, "edge_count after reset");

        for (int f = 1; f <= 3; f++) begin
            send_frame(f);
            random_read_burst();
            sweep_reads(); // Every index, newest frame only
        end

        check(tick_count, 3, "frame_tick pulses in total");
        check(valid_count, 3, "count_valid pulses in total");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* design/edge_capture_top.sv */
`timescale 1ns/1ps

module edge_capture_top import edge_capture_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         canny_de,
    input  logic                         canny_bit,
    input  logic                         rd_req,
    input  logic [pixel_index_width-1:0] rd_index,
    output logic                         frame_tick,
    output logic                         rd_valid,
    output logic                         rd_pixel,
    output logic [count_width-1:0]       edge_count,
    output logic                         count_valid
);

    logic                       we;
    logic [7:0]                 wdata;
    logic [byte_addr_width-1:0] waddr;
    logic                       rd_en;
    logic [byte_addr_width-1:0] rd_addr;
    logic [7:0]                 rd_data;

    edge_pixel_packer u_packer (
        .clk        (clk),
        .reset      (reset),
        .canny_de   (canny_de),
        .canny_bit  (canny_bit),
        .we         (we),
        .wdata      (wdata),
        .waddr      (waddr),
        .frame_tick (frame_tick)
    );

    frame_buffer_ram u_ram (
        .clk     (clk),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    edge_pixel_reader u_reader (
        .clk      (clk),
        .reset    (reset),
        .rd_req   (rd_req),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_pixel (rd_pixel)
    );

    // Watches the same write port as the RAM
    edge_count_stats u_stats (
        .clk         (clk),
        .reset       (reset),
        .we          (we),
        .wdata       (wdata),
        .frame_tick  (frame_tick),
        .edge_count  (edge_count),
        .count_valid (count_valid)
    );

endmodule

/* design/edge_count_stats.sv */
`timescale 1ns/1ps

module edge_count_stats import edge_capture_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  logic [7:0]             wdata,
    input  logic                   frame_tick,
    output logic [count_width-1:0] edge_count,
    output logic                   count_valid
);

    logic [count_width-1:0] sum_reg;
    logic [3:0]             byte_ones;

    // Edge pixels in one packed byte
    function automatic logic [3:0] popcount8(input logic [7:0] b);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, b[i]};
        end
        return n;
    endfunction

    assign byte_ones = popcount8(wdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_reg     <= '0;
            edge_count  <= '0;
            count_valid <= 1'b0;
        end else begin
            count_valid <= frame_tick;
            if (frame_tick) begin
                edge_count <= sum_reg; // Last byte landed the cycle before
                sum_reg    <= '0;
            end else if (we) begin
                sum_reg <= sum_reg + count_width'(byte_ones);
            end
        end
    end

endmodule

/* design/edge_pixel_reader.sv */
`timescale 1ns/1ps

module edge_pixel_reader import edge_capture_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rd_req,
    input  logic [pixel_index_width-1:0] rd_index,
    input  logic [7:0]                   rd_data,
    output logic                         rd_en,
    output logic [byte_addr_width-1:0]   rd_addr,
    output logic                         rd_valid,
    output logic                         rd_pixel
);

    localparam int off_width = $clog2(pixels_per_byte);

    logic                 req_d1;
    logic [off_width-1:0] off_d1;

    // Byte address is p/8, straight to the RAM
    assign rd_en   = rd_req;
    assign rd_addr = rd_index[pixel_index_width-1:off_width];

    // Bit offset waits out the RAM read cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            req_d1 <= 1'b0;
        end else begin
            req_d1 <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        off_d1 <= rd_index[off_width-1:0];
    end

    // Second cycle, pick the bit out of the returned byte
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req_d1;
        end
    end

    always_ff @(posedge clk) begin
        rd_pixel <= rd_data[off_d1];
    end

    // Fixed two-cycle read latency
    a_read_latency: assert property (
        @(posedge clk) disable iff (reset)
        rd_valid == $past(rd_req, 2)
    ) else $error("reader valid does not follow request by two cycles");

endmodule

/* design/frame_buffer_ram.sv */
`timescale 1ns/1ps

module frame_buffer_ram import edge_capture_pkg::*; (
    input  logic                       clk,
    input  logic                       we,
    input  logic [byte_addr_width-1:0] waddr,
    input  logic [7:0]                 wdata,
    input  logic                       rd_en,
    input  logic [byte_addr_width-1:0] rd_addr,
    output logic [7:0]                 rd_data
);

    logic [7:0] mem [frame_bytes]; // One byte per eight pixels

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port, holds its value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* design/edge_pixel_packer.sv */
`timescale 1ns/1ps

module edge_pixel_packer import edge_capture_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       canny_de,
    input  logic                       canny_bit,
    output logic                       we,
    output logic [7:0]                 wdata,
    output logic [byte_addr_width-1:0] waddr,
    output logic                       frame_tick
);

    packer_state_t state, state_next;

    logic [$clog2(pixels_per_byte)-1:0] bit_cnt_reg, bit_cnt_next;
    logic [7:0]                         shift_reg, shift_next;
    logic [7:0]                         wdata_reg, wdata_next;
    logic [byte_addr_width-1:0]         waddr_reg, waddr_next;
    logic                               we_reg, we_next;

    assign we         = we_reg;
    assign wdata      = wdata_reg;
    assign waddr      = waddr_reg;
    assign frame_tick = (state == pk_done); // One cycle after the last write

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= pk_collect;
            bit_cnt_reg <= '0;
            waddr_reg   <= '0;
            we_reg      <= 1'b0;
        end else begin
            state       <= state_next;
            bit_cnt_reg <= bit_cnt_next;
            waddr_reg   <= waddr_next;
            we_reg      <= we_next;
        end
    end

    // Byte payload registers
    always_ff @(posedge clk) begin
        shift_reg <= shift_next;
        wdata_reg <= wdata_next;
    end

    always_comb begin
        state_next   = state;
        bit_cnt_next = bit_cnt_reg;
        shift_next   = shift_reg;
        wdata_next   = wdata_reg;
        waddr_next   = waddr_reg;
        we_next      = 1'b0;

        case (state)
            pk_collect: begin
                // Address moves on once the pending write has gone out
                if (we_reg) begin
                    if (waddr_reg == byte_addr_width'(frame_bytes - 1)) begin
                        state_next = pk_done;
                    end else begin
                        waddr_next = waddr_reg + 1'b1;
                    end
                end

                // Shifting in from the top leaves the first pixel in the LSB
                if (canny_de) begin
                    shift_next   = {canny_bit, shift_reg[7:1]};
                    bit_cnt_next = bit_cnt_reg + 1'b1;
                    if (bit_cnt_reg == 3'd7) begin
                        wdata_next = {canny_bit, shift_reg[7:1]}; // Completed byte
                        we_next    = 1'b1;
                    end
                end
            end

            pk_done: begin
                // Strobes here are dropped
                waddr_next   = '0;
                bit_cnt_next = '0;
                state_next   = pk_collect;
            end

            default: begin
                state_next = pk_collect;
            end
        endcase
    end

    // The tick cycle never carries a write
    a_no_we_on_tick: assert property (
        @(posedge clk) disable iff (reset)
        !(we && frame_tick)
    ) else $error("packer write collides with frame tick");

    // Writes stay inside the frame buffer
    a_waddr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        we |-> (waddr < byte_addr_width'(frame_bytes))
    ) else $error("packer write address out of range");

endmodule

/* design/edge_capture_pkg.sv */
package edge_capture_pkg;

    // Frame geometry of the edge map
    localparam int frame_width  = 160;                        // Pixels per line
    localparam int frame_height = 120;                        // Lines per frame
    localparam int frame_pixels = frame_width * frame_height; // 19,200 pixels

    // One edge bit per pixel, eight pixels share a byte
    localparam int pixels_per_byte = 8;
    localparam int frame_bytes     = frame_pixels / pixels_per_byte; // 2,400 bytes

    // Address and counter widths
    localparam int byte_addr_width   = $clog2(frame_bytes);      // 12 bits
    localparam int pixel_index_width = $clog2(frame_pixels);     // 15 bits
    localparam int count_width       = $clog2(frame_pixels + 1); // Holds a full edge frame

    // Packer FSM
    typedef enum logic [0:0] {
        pk_collect, // Gathering edge bits
        pk_done     // Frame tick, address back to 0
    } packer_state_t;

endpackage
